/* compile.f */
hw/present_pkg.sv
hw/present_round_engine.sv
hw/key_store_arbiter.sv
hw/present_apb_regs.sv
hw/present_subsys_top.sv
test/tb_clock_gen.sv
test/present_subsys_tb.sv

/* hw/key_store_arbiter.sv */
//////////////////////////////////////////////////////////////////////
// key slots behind one port, writes win over engine reads
// read data arrives one cycle after the grant
// slot numbers must be below NumKeySlots
//////////////////////////////////////////////////////////////////////
`default_nettype none

module key_store_arbiter import present_pkg::*; #(
  parameter int  NumKeySlots = 4,
  localparam int SlotW       = (NumKeySlots > 1) ? $clog2(NumKeySlots) : 1
) (
  input  logic             pclk_i,
  input  logic             reset_i,
  input  logic             we_i,
  input  logic [SlotW-1:0] wslot_i,
  input  present_key_t     wdata_i,
  input  logic [1:0]       req_i,
  input  logic [SlotW-1:0] slot0_i,
  input  logic [SlotW-1:0] slot1_i,
  output logic [1:0]       gnt_o,
  output present_key_t     rdata_o
);

  present_key_t     slots_q [NumKeySlots];
  present_key_t     rdata_q;
  // set means engine 1 goes first on a tie
  logic             rr_q;
  logic [SlotW-1:0] rd_slot;

  // write blocks both engines this cycle
  always_comb begin
    gnt_o = 2'b00;
    if (!we_i) begin
      if (req_i == 2'b11) begin
        gnt_o = rr_q ? 2'b10 : 2'b01;
      end else begin
        gnt_o = req_i;
      end
    end
  end

  assign rd_slot = gnt_o[1] ? slot1_i : slot0_i;

  // pointer flips away from whoever just won
  always_ff @(posedge pclk_i) begin
    if (reset_i) begin
      rr_q <= 1'b0;
    end else if (|gnt_o) begin
      rr_q <= gnt_o[0];
    end
  end

  // slot memory and read register
  always_ff @(posedge pclk_i) begin
    if (we_i) begin
      slots_q[wslot_i] <= wdata_i;
    end
    if (|gnt_o) begin
      rdata_q <= slots_q[rd_slot];
    end
  end

  assign rdata_o = rdata_q;

  gnt_onehot_a: assert property (@(posedge pclk_i) disable iff (reset_i)
    $onehot0(gnt_o));

endmodule

`default_nettype wire

/* hw/present_apb_regs.sv */
//////////////////////////////////////////////////////////////////////
// APB3 register block, no wait states, pslverr tied low
// a start while that channel is busy is dropped, slot kept unchanged
// key words are write only and read back as zero
//////////////////////////////////////////////////////////////////////
`default_nettype none

module present_apb_regs import present_pkg::*; #(
  parameter int  NumKeySlots = 4,
  localparam int SlotW       = (NumKeySlots > 1) ? $clog2(NumKeySlots) : 1
) (
  input  logic             pclk_i,
  input  logic             reset_i,
  input  logic             psel_i,
  input  logic             penable_i,
  input  logic             pwrite_i,
  input  logic [11:0]      paddr_i,
  input  logic [31:0]      pwdata_i,
  output logic [31:0]      prdata_o,
  output logic             pready_o,
  output logic             pslverr_o,
  // key store write port
  output logic             key_we_o,
  output logic [SlotW-1:0] key_wslot_o,
  output present_key_t     key_wdata_o,
  // encrypt channel
  output logic             enc_start_o,
  output logic [SlotW-1:0] enc_slot_o,
  output present_block_t   enc_din_o,
  input  logic             enc_busy_i,
  input  logic             enc_done_i,
  input  present_block_t   enc_dout_i,
  // decrypt channel
  output logic             dec_start_o,
  output logic [SlotW-1:0] dec_slot_o,
  output present_block_t   dec_din_o,
  input  logic             dec_busy_i,
  input  logic             dec_done_i,
  input  present_block_t   dec_dout_i
);

  logic             wr_en;
  logic             rd_en;
  logic             ctrl_wr;
  logic [31:0]      rdata;

  present_key_t     key_stage_q;
  present_block_t   enc_din_q;
  present_block_t   dec_din_q;
  logic [SlotW-1:0] enc_slot_q;
  logic [SlotW-1:0] dec_slot_q;
  logic [SlotW-1:0] key_wslot_q;
  logic             key_we_q;
  logic             enc_start_q;
  logic             dec_start_q;

  // access phase only
  assign wr_en   = psel_i & penable_i & pwrite_i;
  assign rd_en   = psel_i & penable_i & ~pwrite_i;
  assign ctrl_wr = wr_en && (paddr_i == CTRL);

  //////////////////////////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////////////////////////

  // one cycle pulses
  always_ff @(posedge pclk_i) begin
    if (reset_i) begin
      key_we_q    <= 1'b0;
      enc_start_q <= 1'b0;
      dec_start_q <= 1'b0;
    end else begin
      key_we_q    <= wr_en && (paddr_i == KEY_CMD);
      enc_start_q <= ctrl_wr && pwdata_i[CTRL_ENC_START] && !enc_busy_i;
      dec_start_q <= ctrl_wr && pwdata_i[CTRL_DEC_START] && !dec_busy_i;
    end
  end

  // staging and data words
  always_ff @(posedge pclk_i) begin
    if (wr_en) begin
      case (paddr_i)
        KEY0:       key_stage_q[31:0]  <= pwdata_i;
        KEY1:       key_stage_q[63:32] <= pwdata_i;
        KEY2:       key_stage_q[79:64] <= pwdata_i[15:0];
        KEY_CMD:    key_wslot_q        <= pwdata_i[SlotW-1:0];
        ENC_DIN_LO: enc_din_q[31:0]    <= pwdata_i;
        ENC_DIN_HI: enc_din_q[63:32]   <= pwdata_i;
        DEC_DIN_LO: dec_din_q[31:0]    <= pwdata_i;
        DEC_DIN_HI: dec_din_q[63:32]   <= pwdata_i;
        default: ;
      endcase
    end
    // slot only follows an accepted start
    if (ctrl_wr && pwdata_i[CTRL_ENC_START] && !enc_busy_i) begin
      enc_slot_q <= pwdata_i[CTRL_ENC_SLOT_LSB +: SlotW];
    end
    if (ctrl_wr && pwdata_i[CTRL_DEC_START] && !dec_busy_i) begin
      dec_slot_q <= pwdata_i[CTRL_DEC_SLOT_LSB +: SlotW];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read side
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    rdata = '0;
    case (paddr_i)
      ENC_DIN_LO:  rdata = enc_din_q[31:0];
      ENC_DIN_HI:  rdata = enc_din_q[63:32];
      DEC_DIN_LO:  rdata = dec_din_q[31:0];
      DEC_DIN_HI:  rdata = dec_din_q[63:32];
      CTRL: begin
        rdata[CTRL_ENC_SLOT_LSB +: SlotW] = enc_slot_q;
        rdata[CTRL_DEC_SLOT_LSB +: SlotW] = dec_slot_q;
      end
      STATUS: begin
        rdata[STAT_ENC_BUSY] = enc_busy_i;
        rdata[STAT_ENC_DONE] = enc_done_i;
        rdata[STAT_DEC_BUSY] = dec_busy_i;
        rdata[STAT_DEC_DONE] = dec_done_i;
      end
      ENC_DOUT_LO: rdata = enc_dout_i[31:0];
      ENC_DOUT_HI: rdata = enc_dout_i[63:32];
      DEC_DOUT_LO: rdata = dec_dout_i[31:0];
      DEC_DOUT_HI: rdata = dec_dout_i[63:32];
      default:     rdata = '0;
    endcase
  end

  // bus idles at zero outside read access
  assign prdata_o    = rd_en ? rdata : '0;
  assign pready_o    = 1'b1;
  assign pslverr_o   = 1'b0;

  assign key_we_o    = key_we_q;
  assign key_wslot_o = key_wslot_q;
  assign key_wdata_o = key_stage_q;
  assign enc_start_o = enc_start_q;
  assign enc_slot_o  = enc_slot_q;
  assign enc_din_o   = enc_din_q;
  assign dec_start_o = dec_start_q;
  assign dec_slot_o  = dec_slot_q;
  assign dec_din_o   = dec_din_q;

  // engine never sees a start it would drop
  no_busy_start_a: assert property (@(posedge pclk_i) disable iff (reset_i)
    !(enc_start_o && enc_busy_i) && !(dec_start_o && dec_busy_i));

endmodule

`default_nettype wire

/* hw/present_pkg.sv */
//////////////////////////////////////////////////////////////////////
// PRESENT-80 helpers: 64-bit block and 80-bit key only
// sbox and permutation layers take an inv flag for the decrypt side
// register offsets are byte addresses of 32-bit words, 12-bit space
//////////////////////////////////////////////////////////////////////
`default_nettype none

package present_pkg;

  localparam int DATA_W     = 64;
  localparam int KEY_W      = 80;
  localparam int NUM_ROUNDS = 31;

  typedef logic [DATA_W-1:0] present_block_t;
  typedef logic [KEY_W-1:0]  present_key_t;
  typedef logic [4:0]        round_idx_t;

  // nibble i of the table sits at bits [4*i +: 4]
  localparam logic [63:0] PRESENT_SBOX4     = 64'h21748FE3DA09B65C;
  localparam logic [63:0] PRESENT_SBOX4_INV = 64'hA970364BD21C8FE5;

  //////////////////////////////////////////////////////////////////////
  // register map
  //////////////////////////////////////////////////////////////////////

  // key staging, KEY0 is the low word
  localparam logic [11:0] KEY0        = 12'h000;
  localparam logic [11:0] KEY1        = 12'h004;
  localparam logic [11:0] KEY2        = 12'h008;
  // write slot number to commit staged key
  localparam logic [11:0] KEY_CMD     = 12'h00C;
  localparam logic [11:0] ENC_DIN_LO  = 12'h010;
  localparam logic [11:0] ENC_DIN_HI  = 12'h014;
  localparam logic [11:0] DEC_DIN_LO  = 12'h018;
  localparam logic [11:0] DEC_DIN_HI  = 12'h01C;
  localparam logic [11:0] CTRL        = 12'h020;
  localparam logic [11:0] STATUS      = 12'h024;
  localparam logic [11:0] ENC_DOUT_LO = 12'h028;
  localparam logic [11:0] ENC_DOUT_HI = 12'h02C;
  localparam logic [11:0] DEC_DOUT_LO = 12'h030;
  localparam logic [11:0] DEC_DOUT_HI = 12'h034;

  // CTRL fields, start bits and per channel slot fields
  localparam int CTRL_ENC_START    = 0;
  localparam int CTRL_DEC_START    = 1;
  localparam int CTRL_ENC_SLOT_LSB = 8;
  localparam int CTRL_DEC_SLOT_LSB = 12;

  // STATUS bits
  localparam int STAT_ENC_BUSY = 0;
  localparam int STAT_ENC_DONE = 1;
  localparam int STAT_DEC_BUSY = 2;
  localparam int STAT_DEC_DONE = 3;

  //////////////////////////////////////////////////////////////////////
  // cipher layers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [3:0] sbox4(logic [3:0] nib, logic inv);
    logic [63:0] tbl;
    tbl = inv ? PRESENT_SBOX4_INV : PRESENT_SBOX4;
    return tbl[4*nib +: 4];
  endfunction

  function automatic present_block_t sbox_layer(present_block_t d, logic inv);
    present_block_t r;
    for (int i = 0; i < DATA_W / 4; i++) begin
      r[4*i +: 4] = sbox4(d[4*i +: 4], inv);
    end
    return r;
  endfunction

  // bit i moves to 16*i mod 63, bit 63 stays put
  function automatic present_block_t perm_layer(present_block_t d, logic inv);
    present_block_t r;
    r[63] = d[63];
    for (int i = 0; i < 63; i++) begin
      if (inv) begin
        r[i] = d[(16 * i) % 63];
      end else begin
        r[(16 * i) % 63] = d[i];
      end
    end
    return r;
  endfunction

  // rotate left 61, sbox on top nibble, counter into bits 19:15
  function automatic present_key_t update_key80(present_key_t key, round_idx_t idx);
    present_key_t k;
    k          = {key[18:0], key[79:19]};
    k[79:76]   = sbox4(k[79:76], 1'b0);
    k[19:15]   = k[19:15] ^ idx;
    return k;
  endfunction

  // exact undo of update_key80 for the same idx
  function automatic present_key_t inv_update_key80(present_key_t key, round_idx_t idx);
    present_key_t k;
    k          = key;
    k[19:15]   = k[19:15] ^ idx;
    k[79:76]   = sbox4(k[79:76], 1'b1);
    k          = {k[60:0], k[79:61]};
    return k;
  endfunction

endpackage

`default_nettype wire

/* hw/present_round_engine.sv */
//////////////////////////////////////////////////////////////////////
// one physical PRESENT-80 round, 31 iterations, one round per cycle
// din_i and slot_i are sampled only on start_i while idle
// key_i is taken only in the cycle after this engine's own grant
// dout_o is valid while done_o is high
//////////////////////////////////////////////////////////////////////
`default_nettype none

module present_round_engine import present_pkg::*; #(
  parameter bit  Decrypt     = 1'b0,
  parameter int  NumKeySlots = 4,
  localparam int SlotW       = (NumKeySlots > 1) ? $clog2(NumKeySlots) : 1
) (
  input  logic             pclk_i,
  input  logic             reset_i,
  input  logic             start_i,
  input  logic [SlotW-1:0] slot_i,
  input  present_block_t   din_i,
  input  logic             key_gnt_i,
  input  present_key_t     key_i,
  output logic             key_req_o,
  output logic [SlotW-1:0] key_slot_o,
  output logic             busy_o,
  output logic             done_o,
  output present_block_t   dout_o
);

  localparam logic [2:0] ST_IDLE   = 3'd0;
  localparam logic [2:0] ST_FETCH  = 3'd1;
  localparam logic [2:0] ST_EXPAND = 3'd2;
  localparam logic [2:0] ST_ROUNDS = 3'd3;
  localparam logic [2:0] ST_FINISH = 3'd4;

  localparam round_idx_t FirstIdx = 5'd1;
  localparam round_idx_t LastIdx  = round_idx_t'(NUM_ROUNDS);
  // enc counts up, dec counts down through the rounds
  localparam round_idx_t EndIdx   = Decrypt ? FirstIdx : LastIdx;

  logic [2:0]       state_q;
  round_idx_t       idx_q;
  logic             key_sel_q;
  logic             done_q;
  logic [SlotW-1:0] slot_q;
  present_block_t   data_q;
  present_key_t     key_q;

  present_key_t     cur_key;
  present_block_t   round_in;
  present_block_t   round_out;
  present_key_t     key_next;

  //////////////////////////////////////////////////////////////////////
  // round datapath
  //////////////////////////////////////////////////////////////////////

  // fresh key from the store in the first cycle after grant
  assign cur_key  = key_sel_q ? key_i : key_q;
  // add round key, top 64 bits
  assign round_in = data_q ^ cur_key[KEY_W-1 -: DATA_W];

  always_comb begin
    if (Decrypt) begin
      round_out = sbox_layer(perm_layer(round_in, 1'b1), 1'b1);
    end else begin
      round_out = perm_layer(sbox_layer(round_in, 1'b0), 1'b0);
    end
  end

  // expansion always runs forward, dec rounds step the schedule back
  assign key_next = (Decrypt && state_q == ST_ROUNDS) ? inv_update_key80(cur_key, idx_q)
                                                      : update_key80(cur_key, idx_q);

  //////////////////////////////////////////////////////////////////////
  // sequencing
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge pclk_i) begin
    if (reset_i) begin
      state_q   <= ST_IDLE;
      idx_q     <= '0;
      key_sel_q <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      key_sel_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (start_i) begin
            state_q <= ST_FETCH;
            done_q  <= 1'b0;
          end
        end
        ST_FETCH: begin
          // key shows up on key_i next cycle
          if (key_gnt_i) begin
            state_q   <= Decrypt ? ST_EXPAND : ST_ROUNDS;
            idx_q     <= FirstIdx;
            key_sel_q <= 1'b1;
          end
        end
        ST_EXPAND: begin
          idx_q <= idx_q + 5'd1;
          // 31 updates done, key_q holds the last round key
          if (idx_q == LastIdx) begin
            state_q <= ST_ROUNDS;
            idx_q   <= LastIdx;
          end
        end
        ST_ROUNDS: begin
          idx_q <= Decrypt ? idx_q - 5'd1 : idx_q + 5'd1;
          if (idx_q == EndIdx) begin
            state_q <= ST_FINISH;
          end
        end
        ST_FINISH: begin
          state_q <= ST_IDLE;
          done_q  <= 1'b1;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // payload, no reset
  always_ff @(posedge pclk_i) begin
    if (state_q == ST_IDLE && start_i) begin
      data_q <= din_i;
      slot_q <= slot_i;
    end
    if (state_q == ST_ROUNDS) begin
      data_q <= round_out;
    end
    // final key whitening
    if (state_q == ST_FINISH) begin
      data_q <= data_q ^ key_q[KEY_W-1 -: DATA_W];
    end
    if (state_q == ST_EXPAND || state_q == ST_ROUNDS) begin
      key_q <= key_next;
    end
  end

  assign key_req_o  = (state_q == ST_FETCH);
  assign key_slot_o = slot_q;
  assign busy_o     = (state_q != ST_IDLE);
  assign done_o     = done_q;
  assign dout_o     = data_q;

  // request and slot held steady across arbitration stalls
  req_hold_a: assert property (@(posedge pclk_i) disable iff (reset_i)
    key_req_o && !key_gnt_i |=> key_req_o && $stable(key_slot_o));

  round_range_a: assert property (@(posedge pclk_i) disable iff (reset_i)
    state_q == ST_ROUNDS |-> idx_q inside {[FirstIdx:LastIdx]});

endmodule

`default_nettype wire

/* hw/present_subsys_top.sv */
//////////////////////////////////////////////////////////////////////
// PRESENT-80 subsystem on APB3, one encrypt and one decrypt channel
// both engines share the key store read port
//////////////////////////////////////////////////////////////////////
`default_nettype none

module present_subsys_top import present_pkg::*; #(
  parameter int  NumKeySlots = 4,
  localparam int SlotW       = (NumKeySlots > 1) ? $clog2(NumKeySlots) : 1
) (
  input  logic        pclk_i,
  input  logic        reset_i,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  logic [11:0] paddr_i,
  input  logic [31:0] pwdata_i,
  output logic [31:0] prdata_o,
  output logic        pready_o,
  output logic        pslverr_o
);

  // key write port
  logic             key_we;
  logic [SlotW-1:0] key_wslot;
  present_key_t     key_wdata;
  // shared read port, index 0 enc, 1 dec
  logic [1:0]       key_req;
  logic [1:0]       key_gnt;
  logic [SlotW-1:0] enc_key_slot;
  logic [SlotW-1:0] dec_key_slot;
  present_key_t     key_rdata;

  logic             enc_start;
  logic             enc_busy;
  logic             enc_done;
  logic [SlotW-1:0] enc_slot;
  present_block_t   enc_din;
  present_block_t   enc_dout;
  logic             dec_start;
  logic             dec_busy;
  logic             dec_done;
  logic [SlotW-1:0] dec_slot;
  present_block_t   dec_din;
  present_block_t   dec_dout;

  present_apb_regs #(
    .NumKeySlots (NumKeySlots)
  ) u_regs (
    .pclk_i      (pclk_i),
    .reset_i     (reset_i),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .paddr_i     (paddr_i),
    .pwdata_i    (pwdata_i),
    .prdata_o    (prdata_o),
    .pready_o    (pready_o),
    .pslverr_o   (pslverr_o),
    .key_we_o    (key_we),
    .key_wslot_o (key_wslot),
    .key_wdata_o (key_wdata),
    .enc_start_o (enc_start),
    .enc_slot_o  (enc_slot),
    .enc_din_o   (enc_din),
    .enc_busy_i  (enc_busy),
    .enc_done_i  (enc_done),
    .enc_dout_i  (enc_dout),
    .dec_start_o (dec_start),
    .dec_slot_o  (dec_slot),
    .dec_din_o   (dec_din),
    .dec_busy_i  (dec_busy),
    .dec_done_i  (dec_done),
    .dec_dout_i  (dec_dout)
  );

  present_round_engine #(
    .Decrypt     (1'b0),
    .NumKeySlots (NumKeySlots)
  ) u_enc (
    .pclk_i     (pclk_i),
    .reset_i    (reset_i),
    .start_i    (enc_start),
    .slot_i     (enc_slot),
    .din_i      (enc_din),
    .key_gnt_i  (key_gnt[0]),
    .key_i      (key_rdata),
    .key_req_o  (key_req[0]),
    .key_slot_o (enc_key_slot),
    .busy_o     (enc_busy),
    .done_o     (enc_done),
    .dout_o     (enc_dout)
  );

  present_round_engine #(
    .Decrypt     (1'b1),
    .NumKeySlots (NumKeySlots)
  ) u_dec (
    .pclk_i     (pclk_i),
    .reset_i    (reset_i),
    .start_i    (dec_start),
    .slot_i     (dec_slot),
    .din_i      (dec_din),
    .key_gnt_i  (key_gnt[1]),
    .key_i      (key_rdata),
    .key_req_o  (key_req[1]),
    .key_slot_o (dec_key_slot),
    .busy_o     (dec_busy),
    .done_o     (dec_done),
    .dout_o     (dec_dout)
  );

  key_store_arbiter #(
    .NumKeySlots (NumKeySlots)
  ) u_keys (
    .pclk_i  (pclk_i),
    .reset_i (reset_i),
    .we_i    (key_we),
    .wslot_i (key_wslot),
    .wdata_i (key_wdata),
    .req_i   (key_req),
    .slot0_i (enc_key_slot),
    .slot1_i (dec_key_slot),
    .gnt_o   (key_gnt),
    .rdata_o (key_rdata)
  );

endmodule

`default_nettype wire

/* test/present_subsys_tb.sv */
//////////////////////////////////////////////////////////////////////
// APB testbench for the PRESENT-80 subsystem, 4 key slots
// expected values come from the published PRESENT-80 vectors
// random rows check the enc/dec round trip on both channels at once
//////////////////////////////////////////////////////////////////////
`default_nettype none

module present_subsys_tb import present_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int KeySlots    = 4;
  localparam int PeriodNs    = 100;
  localparam int ResetCycles = 8;
  localparam int NumPub      = 4;
  localparam int NumRand     = 4;
  // enc rows, dec rows, two steps per random row, key rewrite, busy start
  localparam int NumRows     = 2 * NumPub + 2 * NumRand + 2;
  localparam int WatchdogCyc = NumRows * 200 + ResetCycles;
  localparam int PollLimit   = 100;

  localparam logic [31:0] EncBusy = 32'd1 << STAT_ENC_BUSY;
  localparam logic [31:0] EncDone = 32'd1 << STAT_ENC_DONE;
  localparam logic [31:0] DecBusy = 32'd1 << STAT_DEC_BUSY;
  localparam logic [31:0] DecDone = 32'd1 << STAT_DEC_DONE;
  localparam logic [31:0] EncMask = EncBusy | EncDone;
  localparam logic [31:0] DecMask = DecBusy | DecDone;

  logic        pclk;
  logic        reset;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [11:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  int          err_cnt;
  int          tests_run;
  int          tests_failed;
  int          test_err_base;
  logic [31:0] rng_state;

  // published vector table, row i lives in key slot pub_slot[i]
  present_block_t pub_pt  [NumPub];
  present_key_t   pub_key [NumPub];
  present_block_t pub_ct  [NumPub];
  int             pub_slot[NumPub];

  tb_clock_gen #(
    .PeriodNs    (PeriodNs),
    .ResetCycles (ResetCycles)
  ) u_clk (
    .clk_o   (pclk),
    .reset_o (reset)
  );

  present_subsys_top #(
    .NumKeySlots (KeySlots)
  ) present_subsys_top_i (
    .pclk_i    (pclk),
    .reset_i   (reset),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .paddr_i   (paddr),
    .pwdata_i  (pwdata),
    .prdata_o  (prdata),
    .pready_o  (pready),
    .pslverr_o (pslverr)
  );

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic next_block(output present_block_t b);
    logic [31:0] hi;
    rng_state = xorshift32(rng_state);
    hi = rng_state;
    rng_state = xorshift32(rng_state);
    b = {hi, rng_state};
  endtask

  task automatic fill_table();
    pub_pt[0]  = 64'h0000_0000_0000_0000;
    pub_key[0] = 80'h0000_0000_0000_0000_0000;
    pub_ct[0]  = 64'h5579_C138_7B22_8445;
    pub_pt[1]  = 64'h0000_0000_0000_0000;
    pub_key[1] = 80'hFFFF_FFFF_FFFF_FFFF_FFFF;
    pub_ct[1]  = 64'hE72C_46C0_F594_5049;
    pub_pt[2]  = 64'hFFFF_FFFF_FFFF_FFFF;
    pub_key[2] = 80'h0000_0000_0000_0000_0000;
    pub_ct[2]  = 64'hA112_FFC7_2F68_417B;
    pub_pt[3]  = 64'hFFFF_FFFF_FFFF_FFFF;
    pub_key[3] = 80'hFFFF_FFFF_FFFF_FFFF_FFFF;
    pub_ct[3]  = 64'h3333_DCD3_2132_10D2;
    for (int i = 0; i < NumPub; i++) begin
      pub_slot[i] = i % KeySlots;
    end
  endtask

  function automatic logic [31:0] ctrl_word(input logic enc_go, input int enc_slot,
                                            input logic dec_go, input int dec_slot);
    logic [31:0] w;
    w = '0;
    w[CTRL_ENC_START] = enc_go;
    w[CTRL_DEC_START] = dec_go;
    w[CTRL_ENC_SLOT_LSB +: 4] = enc_slot[3:0];
    w[CTRL_DEC_SLOT_LSB +: 4] = dec_slot[3:0];
    return w;
  endfunction

  task automatic check_block(input string name, input present_block_t exp,
                             input present_block_t act);
    if (act !== exp) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_status(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    if (act !== exp) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      err_cnt++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // APB transfers, setup then access, idle cycle after
  //////////////////////////////////////////////////////////////////////

  task automatic write_reg(input logic [11:0] addr, input logic [31:0] data);
    @(posedge pclk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge pclk);
    penable <= 1'b1;
    // pready tied high, so the access ends this cycle
    @(negedge pclk);
    if (pready !== 1'b1 || pslverr !== 1'b0) begin
      $display("write to %h did not complete with ready high and no error", addr);
      err_cnt++;
    end
    @(posedge pclk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic read_reg(input logic [11:0] addr, output logic [31:0] data);
    @(posedge pclk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge pclk);
    penable <= 1'b1;
    // mid access cycle, read data settled
    @(negedge pclk);
    data = prdata;
    if (pready !== 1'b1 || pslverr !== 1'b0) begin
      $display("read from %h did not complete with ready high and no error", addr);
      err_cnt++;
    end
    @(posedge pclk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic load_key(input int slot, input present_key_t key);
    write_reg(KEY0, key[31:0]);
    write_reg(KEY1, key[63:32]);
    write_reg(KEY2, {16'h0000, key[79:64]});
    // commit staged key into the slot
    write_reg(KEY_CMD, slot);
  endtask

  task automatic set_din(input logic dec, input present_block_t b);
    write_reg(dec ? DEC_DIN_LO : ENC_DIN_LO, b[31:0]);
    write_reg(dec ? DEC_DIN_HI : ENC_DIN_HI, b[63:32]);
  endtask

  task automatic read_result(input logic dec, output present_block_t b);
    logic [31:0] lo;
    logic [31:0] hi;
    read_reg(dec ? DEC_DOUT_LO : ENC_DOUT_LO, lo);
    read_reg(dec ? DEC_DOUT_HI : ENC_DOUT_HI, hi);
    b = {hi, lo};
  endtask

  // poll until every channel in done_mask reports done
  task automatic wait_done(input logic [31:0] done_mask, output logic [31:0] st);
    logic finished;
    int   polls;
    polls = 0;
    read_reg(STATUS, st);
    finished = ((st & done_mask) == done_mask);
    while (!finished && polls < PollLimit) begin
      read_reg(STATUS, st);
      polls++;
      finished = ((st & done_mask) == done_mask);
    end
    if (!finished) begin
      $display("channel did not report done within %0d status polls", PollLimit);
      err_cnt++;
    end
  endtask

  task automatic close_test(input string name);
    tests_run++;
    if (err_cnt != test_err_base) begin
      tests_failed++;
      $display("test %0d %s: failed", tests_run, name);
    end else begin
      $display("test %0d %s: passed", tests_run, name);
    end
    test_err_base = err_cnt;
  endtask

  //////////////////////////////////////////////////////////////////////
  // channel jobs
  //////////////////////////////////////////////////////////////////////

  task automatic encrypt_one(input string name, input present_block_t pt, input int slot,
                             input present_block_t exp);
    logic [31:0]    st;
    present_block_t res;
    set_din(1'b0, pt);
    write_reg(CTRL, ctrl_word(1'b1, slot, 1'b0, 0));
    wait_done(EncDone, st);
    check_status("STATUS", EncDone, st & EncMask);
    read_result(1'b0, res);
    check_block("ENC_DOUT", exp, res);
    close_test(name);
  endtask

  task automatic decrypt_one(input string name, input present_block_t ct, input int slot,
                             input present_block_t exp);
    logic [31:0]    st;
    present_block_t res;
    set_din(1'b1, ct);
    write_reg(CTRL, ctrl_word(1'b0, 0, 1'b1, slot));
    wait_done(DecDone, st);
    check_status("STATUS", DecDone, st & DecMask);
    read_result(1'b1, res);
    check_block("DEC_DOUT", exp, res);
    close_test(name);
  endtask

  // both channels started by one CTRL write
  task automatic run_both(input present_block_t enc_pt, input int enc_slot,
                          input present_block_t dec_ct, input int dec_slot,
                          output present_block_t enc_res, output present_block_t dec_res);
    logic [31:0] st;
    set_din(1'b0, enc_pt);
    set_din(1'b1, dec_ct);
    write_reg(CTRL, ctrl_word(1'b1, enc_slot, 1'b1, dec_slot));
    wait_done(EncDone | DecDone, st);
    check_status("STATUS", EncDone | DecDone, st & (EncMask | DecMask));
    read_result(1'b0, enc_res);
    read_result(1'b1, dec_res);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0]    st;
    present_block_t rnd_pt;
    present_block_t rnd_ct;
    present_block_t enc_res;
    present_block_t dec_res;
    int             s;
    int             j;

    psel          <= 1'b0;
    penable       <= 1'b0;
    pwrite        <= 1'b0;
    paddr         <= '0;
    pwdata        <= '0;
    err_cnt       = 0;
    tests_run     = 0;
    tests_failed  = 0;
    test_err_base = 0;
    rng_state     = 32'd30182;
    fill_table();

    @(posedge pclk);
    while (reset) @(posedge pclk);

    // nothing busy or done out of reset
    read_reg(STATUS, st);
    check_status("STATUS", 32'h0, st);
    close_test("status after reset");

    for (int i = 0; i < NumPub; i++) begin
      load_key(pub_slot[i], pub_key[i]);
    end
    for (int i = 0; i < NumPub; i++) begin
      encrypt_one($sformatf("encrypt vector %0d", i), pub_pt[i], pub_slot[i], pub_ct[i]);
    end
    for (int i = 0; i < NumPub; i++) begin
      decrypt_one($sformatf("decrypt vector %0d", i), pub_ct[i], pub_slot[i], pub_pt[i]);
    end

    // random plaintext on one channel, a known vector on the other
    for (int r = 0; r < NumRand; r++) begin
      s = r % NumPub;
      j = (r + 1) % NumPub;
      next_block(rnd_pt);
      run_both(rnd_pt, pub_slot[s], pub_ct[j], pub_slot[j], rnd_ct, dec_res);
      check_block("DEC_DOUT", pub_pt[j], dec_res);
      close_test($sformatf("random %0d encrypt beside vector decrypt", r));
      // swap roles, the random ciphertext must come back
      run_both(pub_pt[j], pub_slot[j], rnd_ct, pub_slot[s], enc_res, dec_res);
      check_block("ENC_DOUT", pub_ct[j], enc_res);
      check_block("DEC_DOUT", rnd_pt, dec_res);
      close_test($sformatf("random %0d round trip beside vector encrypt", r));
    end

    // slot 0 now gets row 1 key
    load_key(0, pub_key[1]);
    encrypt_one("rewritten key slot", pub_pt[1], 0, pub_ct[1]);

    // second start lands while the engine is busy
    set_din(1'b0, pub_pt[3]);
    write_reg(CTRL, ctrl_word(1'b1, pub_slot[3], 1'b0, 0));
    set_din(1'b0, pub_pt[2]);
    write_reg(CTRL, ctrl_word(1'b1, pub_slot[2], 1'b0, 0));
    read_reg(STATUS, st);
    check_status("STATUS", EncBusy, st & EncMask);
    wait_done(EncDone, st);
    read_result(1'b0, enc_res);
    check_block("ENC_DOUT", pub_ct[3], enc_res);
    close_test("start while busy ignored");

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0 && tests_failed == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // watchdog sized from the row count
  initial begin
    repeat (WatchdogCyc) @(posedge pclk);
    $display("timeout, run did not finish within %0d clock cycles", WatchdogCyc);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* test/tb_clock_gen.sv */
//////////////////////////////////////////////////////////////////////
// free running testbench clock, 50% duty
// reset high from time zero, released on a rising edge
//////////////////////////////////////////////////////////////////////
`default_nettype none

module tb_clock_gen #(
  parameter int PeriodNs    = 100,
  parameter int ResetCycles = 8
) (
  output logic clk_o,
  output logic reset_o
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // synchronous release, so the DUT sees a clean edge
  initial begin
    reset_o = 1'b1;
    repeat (ResetCycles) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

`default_nettype wire
